// ==== Makefile ====
# Verilator build for the MLP core testbench.

VERILATOR ?= verilator
TOP ?= mlpCoreTb
OBJ_DIR ?= obj_dir
FILE_LIST ?= compile.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(wildcard rtl/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@output="$$(./$(SIM_BIN))"; \
	echo "$$output"; \
	if echo "$$output" | grep -q "$(PASS_TEXT)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+include
rtl/mlpPkg.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/classSelect.sv
rtl/mlpCore.sv
dv/mlpCoreTb.sv

// ==== dv/mlpCoreTb.sv ====
`timescale 1ns/1ps
`include "mlp_config.svh"

module mlpCoreTb
	import mlpPkg::*;
;

	localparam int DRAIN = 10;
	localparam int RANDOM_COUNT = 200;
	localparam int SEARCH_TRIES = 4000;
	localparam int MATCH_ZERO = 0;
	localparam int MATCH_TIE = 1;
	localparam int CYCLE_LIMIT = 6 + (12 + DRAIN) + (RANDOM_COUNT + DRAIN)
		+ (16 + DRAIN) + (16 + DRAIN) + (8 + DRAIN) + 50;

	logic clk;
	logic reset;
	inputVec_t features;
	scoreVec_t scores;
	classIdx_t classIndex;

	int cycle;
	int errorCount;
	int passCount;
	int failCount;
	int errorsAtStart;

	inputVec_t stimQ[$];
	scoreVec_t scoreQ[$];
	int scoreDueQ[$];
	classIdx_t idxQ[$];
	int idxDueQ[$];

	scoreVec_t modelScores;
	scoreVec_t expScores;
	classIdx_t expIndex;
	logic scoreCheck;
	logic idxCheck;

	mlpCore UUT
	(
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIndex(classIndex)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// Reference neuron: clamp after rounding.
	function automatic activation_t neuronModel(int sum);
		int r;
		if (sum < 0)
			return '0;
		r = (sum >>> `FRAC_SHIFT) + ((sum >>> (`FRAC_SHIFT - 1)) & 1);
		if (r > 127)
			r = 127;
		return activation_t'(r);
	endfunction

	function automatic hiddenVec_t hiddenModel(inputVec_t f);
		hiddenVec_t h;
		int s;
		for (int n = 0; n < `NUM_HIDDEN; n++)
		begin
			s = int'(HIDDEN_BIAS[n]);
			for (int i = 0; i < `NUM_INPUTS; i++)
				s += int'(HIDDEN_WEIGHTS[n][i]) * int'(f[i]);
			h[n] = neuronModel(s);
		end
		return h;
	endfunction

	function automatic scoreVec_t scoreModel(hiddenVec_t h);
		scoreVec_t sc;
		int s;
		for (int c = 0; c < `NUM_CLASSES; c++)
		begin
			s = int'(OUTPUT_BIAS[c]);
			for (int j = 0; j < `NUM_HIDDEN; j++)
				s += int'(OUTPUT_WEIGHTS[c][j]) * int'(h[j]);
			sc[c] = neuronModel(s);
		end
		return sc;
	endfunction

	// First index holding the largest score.
	function automatic classIdx_t argmaxModel(scoreVec_t sc);
		int best;
		best = 0;
		for (int i = 1; i < `NUM_CLASSES; i++)
			if (int'(sc[i]) > int'(sc[best]))
				best = i;
		return classIdx_t'(best);
	endfunction

	function automatic inputVec_t randomVector();
		inputVec_t f;
		for (int i = 0; i < `NUM_INPUTS; i++)
			f[i] = activation_t'($urandom);
		return f;
	endfunction

	// Drives every product of neuron n the same way, up or down.
	function automatic inputVec_t extremeVector(int n, bit up);
		inputVec_t f;
		int w;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			w = int'(HIDDEN_WEIGHTS[n][i]);
			if (w == 0)
				f[i] = '0;
			else if ((w > 0) == up)
				f[i] = 8'sd127;
			else
				f[i] = -8'sd128;
		end
		return f;
	endfunction

	// Greedy fill that brings the sum of neuron n just under 2^13.
	function automatic inputVec_t nearCarryVector(int n);
		inputVec_t f;
		int rest;
		int w;
		int mag;
		rest = 8191 - int'(HIDDEN_BIAS[n]);
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			w = int'(HIDDEN_WEIGHTS[n][i]);
			f[i] = '0;
			if (w != 0)
			begin
				mag = rest / (w < 0 ? -w : w);
				if (w > 0 && mag > 127)
					mag = 127;
				if (w < 0 && mag > 128)
					mag = 128;
				f[i] = activation_t'(w > 0 ? mag : -mag);
				rest -= w * int'(f[i]);
			end
		end
		return f;
	endfunction

	function automatic bit isMatch(int mode, scoreVec_t sc);
		int top;
		int hits;
		if (mode == MATCH_ZERO)
			return sc == '0;
		top = int'(sc[argmaxModel(sc)]);
		hits = 0;
		for (int i = 0; i < `NUM_CLASSES; i++)
			if (int'(sc[i]) == top)
				hits++;
		return hits > 1;
	endfunction

	task automatic findVectors(input int mode, input int wanted);
		inputVec_t f;
		int found;
		found = 0;
		for (int t = 0; t < SEARCH_TRIES && found < wanted; t++)
		begin
			f = randomVector();
			if (isMatch(mode, scoreModel(hiddenModel(f))))
			begin
				stimQ.push_back(f);
				found++;
			end
		end
		$display("Search mode %0d found %0d vectors", mode, found);
	endtask

	task automatic applyQueued();
		while (stimQ.size() > 0)
		begin
			@(posedge clk);
			features <= stimQ.pop_front();
		end
	endtask

	task automatic reportTest(input string name);
		if (errorCount == errorsAtStart)
		begin
			passCount++;
			$display("Test %s passed", name);
		end
		else
		begin
			failCount++;
			$display("Test %s failed with %0d errors", name, errorCount - errorsAtStart);
		end
		errorsAtStart = errorCount;
	endtask

	task automatic finishTest(input string name);
		repeat (DRAIN) @(posedge clk);
		reportTest(name);
	endtask

	// Expected values fall due 6 and 7 edges after the features are sampled.
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (!reset)
		begin
			modelScores = scoreModel(hiddenModel(features));
			scoreQ.push_back(modelScores);
			scoreDueQ.push_back(cycle + 6);
			idxQ.push_back(argmaxModel(modelScores));
			idxDueQ.push_back(cycle + 7);
		end
		if (scoreDueQ.size() > 0 && scoreDueQ[0] == cycle)
		begin
			void'(scoreDueQ.pop_front());
			void'(scoreQ.pop_front());
		end
		if (idxDueQ.size() > 0 && idxDueQ[0] == cycle)
		begin
			void'(idxDueQ.pop_front());
			void'(idxQ.pop_front());
		end
		scoreCheck <= scoreDueQ.size() > 0 && scoreDueQ[0] == cycle + 1;
		expScores <= scoreQ.size() > 0 ? scoreQ[0] : '0;
		idxCheck <= idxDueQ.size() > 0 && idxDueQ[0] == cycle + 1;
		expIndex <= idxQ.size() > 0 ? idxQ[0] : '0;
	end

	scoresMatch: assert property (@(posedge clk) scoreCheck |-> scores == expScores)
	else
	begin
		errorCount++;
		$display("CHECK FAILED scores expected %h actual %h", expScores, scores);
	end

	indexMatch: assert property (@(posedge clk) idxCheck |-> classIndex == expIndex)
	else
	begin
		errorCount++;
		$display("CHECK FAILED classIndex expected %h actual %h", expIndex, classIndex);
	end

	// Covers the reset cycles and the first edge after release.
	resetClears: assert property (
		@(posedge clk) (cycle > 1 && ($past(reset) || $past(reset, 2)))
			|-> (scores == '0 && classIndex == '0)
	)
	else
	begin
		errorCount++;
		$display("CHECK FAILED scores %h classIndex %h after reset", scores, classIndex);
	end

	always @(posedge clk)
	begin
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles", cycle);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'hd662));
		reset = 1'b1;
		features = '0;
		cycle = 0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		errorsAtStart = 0;
		scoreCheck = 1'b0;
		idxCheck = 1'b0;
		expScores = '0;
		expIndex = '0;

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);
		reportTest("reset");

		// Features already held at zero.
		repeat (12) @(posedge clk);
		finishTest("zeroFeatures");

		for (int v = 0; v < RANDOM_COUNT; v++)
			stimQ.push_back(randomVector());
		applyQueued();
		finishTest("randomStream");

		for (int n = 0; n < `NUM_HIDDEN; n++)
		begin
			stimQ.push_back(extremeVector(n, 1'b1));
			stimQ.push_back(nearCarryVector(n));
		end
		applyQueued();
		finishTest("saturation");

		for (int n = 0; n < `NUM_HIDDEN; n++)
			stimQ.push_back(extremeVector(n, 1'b0));
		findVectors(MATCH_ZERO, 8);
		applyQueued();
		finishTest("negativeClamp");

		findVectors(MATCH_TIE, 8);
		applyQueued();
		finishTest("ties");

		$display("Tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== include/mlp_config.svh ====
`ifndef MLP_CONFIG_SVH
`define MLP_CONFIG_SVH

// Activations and weights share one width.
`define ACT_WIDTH 8

// Largest value a neuron may produce.
`define ACT_MAX ((1 << (`ACT_WIDTH - 1)) - 1)

`define BIAS_WIDTH 16

// Full width of one activation times weight product.
`define PROD_WIDTH (2 * `ACT_WIDTH)

// Neuron accumulator, wide enough for fifteen products plus the bias.
`define ACC_WIDTH 23

// Sum is rescaled by this shift, the bit below it rounds.
`define FRAC_SHIFT 6

// Any set bit from here up to the sign forces saturation.
`define SAT_LIMIT_BIT 13

// Layer sizes.
`define NUM_INPUTS 15
`define NUM_HIDDEN 8
`define NUM_CLASSES 4

// Enough bits to name every class.
`define CLASS_IDX_WIDTH 2

`endif

// ==== rtl/classSelect.sv ====
`timescale 1ns/1ps
`include "mlp_config.svh"

module classSelect
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input scoreVec_t scores,
	output classIdx_t classIndex
);

	classIdx_t bestIdx;
	activation_t bestScore;

	// Strict compare keeps the lowest index on a tie.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int i = 1; i < `NUM_CLASSES; i++)
		begin
			if (scores[i] > bestScore)
			begin
				bestIdx = classIdx_t'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
		end
		else
		begin
			classIndex <= bestIdx;
		end
	end

	// Winner must be at least as large as every other score of the cycle before.
	for (genvar w = 0; w < `NUM_CLASSES; w++)
	begin : gWinner
		for (genvar k = 0; k < `NUM_CLASSES; k++)
		begin : gOther
			if (k != w)
			begin : gCheck
				winnerNotSmaller: assert property (
					@(posedge clk) disable iff (reset)
					(!$past(reset) && classIndex == classIdx_t'(w))
						|-> ($past(scores[w]) >= $past(scores[k]))
				)
				else
					$error("class %0d won but class %0d scored higher", w, k);
			end
		end
	end

endmodule

// ==== rtl/denseLayer.sv ====
`timescale 1ns/1ps
`include "mlp_config.svh"

module denseLayer
	import mlpPkg::*;
#(
	parameter int NUM_IN = `NUM_INPUTS,
	parameter int NUM_OUT = `NUM_HIDDEN,
	parameter weight_t [0:NUM_OUT-1][0:NUM_IN-1] layerWeights = '0,
	parameter bias_t [0:NUM_OUT-1] layerBias = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t [NUM_IN-1:0] inputs,
	output activation_t [NUM_OUT-1:0] outputs
);

	// Every neuron sees the whole input vector.
	// Each takes one row of the table and one bias.
	for (genvar n = 0; n < NUM_OUT; n++)
	begin : gNeuron
		neuronNode #(
			.NUM_IN(NUM_IN),
			.weights(layerWeights[n]),
			.bias(layerBias[n])
		)
		node
		(
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.result(outputs[n])
		);
	end

endmodule

// ==== rtl/mlpCore.sv ====
`timescale 1ns/1ps
`include "mlp_config.svh"

module mlpCore
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input inputVec_t features,
	output scoreVec_t scores,
	output classIdx_t classIndex
);

	hiddenVec_t hiddenAct;

	// Three cycles through the hidden layer.
	denseLayer #(
		.NUM_IN(`NUM_INPUTS),
		.NUM_OUT(`NUM_HIDDEN),
		.layerWeights(HIDDEN_WEIGHTS),
		.layerBias(HIDDEN_BIAS)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.outputs(hiddenAct)
	);

	// Three more to the scores, six in all.
	denseLayer #(
		.NUM_IN(`NUM_HIDDEN),
		.NUM_OUT(`NUM_CLASSES),
		.layerWeights(OUTPUT_WEIGHTS),
		.layerBias(OUTPUT_BIAS)
	)
	outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inputs(hiddenAct),
		.outputs(scores)
	);

	// Index trails the scores by one cycle.
	classSelect classSelector
	(
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIndex(classIndex)
	);

endmodule

// ==== rtl/mlpPkg.sv ====
`include "mlp_config.svh"

package mlpPkg;

	typedef logic signed [`ACT_WIDTH-1:0] activation_t;
	typedef logic signed [`ACT_WIDTH-1:0] weight_t;
	typedef logic signed [`BIAS_WIDTH-1:0] bias_t;

	// Element i of a vector is activation i.
	typedef activation_t [`NUM_INPUTS-1:0] inputVec_t;
	typedef activation_t [`NUM_HIDDEN-1:0] hiddenVec_t;
	typedef activation_t [`NUM_CLASSES-1:0] scoreVec_t;

	typedef logic [`CLASS_IDX_WIDTH-1:0] classIdx_t;

	// Row n is hidden neuron n, column i weighs feature i.
	parameter weight_t [0:`NUM_HIDDEN-1][0:`NUM_INPUTS-1] HIDDEN_WEIGHTS = '{
		'{-8'sd20,  8'sd10,  8'sd0,   8'sd50,  8'sd18, -8'sd4,   8'sd42,  8'sd30,
		  -8'sd6,  -8'sd26,  8'sd26,  8'sd18, -8'sd58,  8'sd8,   8'sd12},
		'{ 8'sd14, -8'sd32,  8'sd27,  8'sd5,  -8'sd11,  8'sd40, -8'sd9,   8'sd22,
		   8'sd35, -8'sd17,  8'sd3,  -8'sd45,  8'sd19,  8'sd28, -8'sd6},
		'{ 8'sd33,  8'sd7,  -8'sd24, -8'sd15,  8'sd46,  8'sd12,  8'sd20, -8'sd38,
		   8'sd9,   8'sd16, -8'sd27,  8'sd31, -8'sd4,  -8'sd13,  8'sd25},
		'{-8'sd8,   8'sd29,  8'sd41, -8'sd36,  8'sd2,   8'sd23, -8'sd19,  8'sd11,
		  -8'sd44,  8'sd37,  8'sd15, -8'sd7,   8'sd26, -8'sd21,  8'sd34},
		'{ 8'sd21, -8'sd13,  8'sd6,   8'sd39, -8'sd28, -8'sd5,   8'sd30,  8'sd17,
		   8'sd24, -8'sd9,  -8'sd40,  8'sd13,  8'sd36,  8'sd10, -8'sd18},
		'{-8'sd35,  8'sd18,  8'sd12,  8'sd7,   8'sd44, -8'sd22, -8'sd3,   8'sd27,
		  -8'sd16,  8'sd31,  8'sd20, -8'sd29,  8'sd5,   8'sd38,  8'sd9},
		'{ 8'sd16,  8'sd25, -8'sd41,  8'sd22, -8'sd7,   8'sd34,  8'sd11, -8'sd20,
		   8'sd28,  8'sd6,   8'sd43,  8'sd14, -8'sd33, -8'sd2,   8'sd19},
		'{ 8'sd4,  -8'sd26,  8'sd37, -8'sd12,  8'sd30,  8'sd9,  -8'sd45,  8'sd15,
		   8'sd21,  8'sd40, -8'sd10,  8'sd24,  8'sd17, -8'sd31,  8'sd3}
	};

	// A bias of 64 adds one unit to the rescaled result.
	parameter bias_t [0:`NUM_HIDDEN-1] HIDDEN_BIAS = '{
		-16'sd512,
		16'sd640,
		16'sd256,
		-16'sd128,
		16'sd384,
		16'sd0,
		16'sd832,
		-16'sd320
	};

	// Row n is class n, column j weighs hidden neuron j.
	parameter weight_t [0:`NUM_CLASSES-1][0:`NUM_HIDDEN-1] OUTPUT_WEIGHTS = '{
		'{ 8'sd22, -8'sd15,  8'sd31,  8'sd8,  -8'sd27,  8'sd19,  8'sd12, -8'sd6},
		'{-8'sd18,  8'sd26,  8'sd7,  -8'sd33,  8'sd14,  8'sd29, -8'sd9,   8'sd21},
		'{ 8'sd35,  8'sd4,  -8'sd21,  8'sd17,  8'sd10, -8'sd12,  8'sd28, -8'sd24},
		'{-8'sd5,   8'sd30,  8'sd16,  8'sd11, -8'sd30,  8'sd23, -8'sd14,  8'sd27}
	};

	parameter bias_t [0:`NUM_CLASSES-1] OUTPUT_BIAS = '{
		-16'sd200,
		16'sd150,
		-16'sd400,
		16'sd64
	};

endpackage

// ==== rtl/neuronNode.sv ====
`timescale 1ns/1ps
`include "mlp_config.svh"

module neuronNode
	import mlpPkg::*;
#(
	parameter int NUM_IN = `NUM_INPUTS,
	parameter weight_t [0:NUM_IN-1] weights = '0,
	parameter bias_t bias = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t [NUM_IN-1:0] inputs,
	output activation_t result
);

	activation_t [NUM_IN-1:0] inputsReg;
	logic signed [`PROD_WIDTH-1:0] products [NUM_IN];
	logic signed [`ACC_WIDTH-1:0] sumComb;
	logic signed [`ACC_WIDTH-1:0] sumReg;
	logic [`ACT_WIDTH-1:0] rounded;
	activation_t reluComb;

	// Signed products, sign extended into the accumulator.
	always_comb
	begin
		sumComb = {{(`ACC_WIDTH-`BIAS_WIDTH){bias[`BIAS_WIDTH-1]}}, bias};
		for (int i = 0; i < NUM_IN; i++)
		begin
			products[i] = inputsReg[i] * weights[i];
			sumComb = sumComb
				+ {{(`ACC_WIDTH-`PROD_WIDTH){products[i][`PROD_WIDTH-1]}}, products[i]};
		end
	end

	// Round first, then clamp, so the carry out of rounding cannot reach 128.
	always_comb
	begin
		rounded = {1'b0, sumReg[`SAT_LIMIT_BIT-1:`FRAC_SHIFT]}
			+ {{(`ACT_WIDTH-1){1'b0}}, sumReg[`FRAC_SHIFT-1]};
		if (sumReg[`ACC_WIDTH-1])
		begin
			reluComb = '0;
		end
		else if (|sumReg[`ACC_WIDTH-2:`SAT_LIMIT_BIT] || rounded > `ACT_MAX)
		begin
			reluComb = activation_t'(`ACT_MAX);
		end
		else
		begin
			reluComb = activation_t'(rounded);
		end
	end

	// Input, sum and output stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sumReg <= sumComb;
			result <= reluComb;
		end
	end

	resultNeverNegative: assert property (
		@(posedge clk) disable iff (reset)
		!result[`ACT_WIDTH-1]
	)
	else
		$error("neuron result %0h has its top bit set", result);

endmodule
